// ==== glb_settings.svh ====
`ifndef GLB_SETTINGS_SVH
`define GLB_SETTINGS_SVH

// ##################################################
// Bank geometry
// ##################################################

// Bits per bank word.
`define GLB_SRAM_BIT  32

// Bank depth in words.
`define GLB_SRAM_WORD 64

`endif

// ==== glb_pkg.sv ====
`include "glb_settings.svh"

package glb_pkg;

    // ##################################################
    // Vector types
    // ##################################################
    typedef logic [`GLB_SRAM_BIT-1:0]               glb_data_t;
    typedef logic [$clog2(`GLB_SRAM_WORD)-1:0]      glb_addr_t;
    typedef logic [$clog2(`GLB_SRAM_WORD + 1)-1:0]  glb_count_t; // Holds a full bank.

    // ##################################################
    // Bank requests and batch handoff
    // ##################################################
    typedef struct packed {
        logic      en;
        glb_addr_t addr;
        glb_data_t data;
    } glb_wr_req_t;

    typedef struct packed {
        logic      en;
        glb_addr_t addr;
    } glb_rd_req_t;

    typedef struct packed {
        logic       done;
        glb_count_t words;
    } glb_fill_t;

    // State machines.
    typedef enum logic [1:0] {ld_idle, ld_fill, ld_wait_drain} loader_state_t;
    typedef enum logic [1:0] {dr_idle, dr_read, dr_sum} drainer_state_t;

endpackage

// ==== glb_ram.sv ====
`timescale 1ns/100ps
`include "glb_settings.svh"

module glb_ram (
    input  logic                 clk,
    input  logic                 rst_n,
    input  glb_pkg::glb_wr_req_t wr_req,
    input  glb_pkg::glb_rd_req_t rd_req,
    output glb_pkg::glb_data_t   rd_data
);

    import glb_pkg::*;

    glb_data_t mem [`GLB_SRAM_WORD];
    glb_addr_t bank_addr;
    logic      bank_cs;
    glb_data_t bank_q;     // Raw bank output.
    logic      rd_en_d;
    glb_data_t q_hold;

    // ##################################################
    // Single-port array
    // ##################################################

    // Write strobe takes the address.
    assign bank_addr = wr_req.en ? wr_req.addr : rd_req.addr;
    assign bank_cs   = wr_req.en | rd_req.en;

    always_ff @(posedge clk) begin
        if (wr_req.en) begin
            mem[bank_addr] <= wr_req.data;
        end
    end

    // Output changes on every access.
    // A write shows its own data.
    always_ff @(posedge clk) begin
        if (bank_cs) begin
            bank_q <= wr_req.en ? wr_req.data : mem[bank_addr];
        end
    end

    // ##################################################
    // Output hold
    // ##################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en_d <= 1'b0;
        end else begin
            rd_en_d <= rd_req.en;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_hold <= '0;
        end else if (rd_en_d) begin
            q_hold <= bank_q;    // Lock last read word.
        end
    end

    assign rd_data = rd_en_d ? bank_q : q_hold;

endmodule

// ==== glb_loader.sv ====
`timescale 1ns/100ps
`include "glb_settings.svh"

module glb_loader (
    input  logic                 clk,
    input  logic                 rst_n,
    input  glb_pkg::glb_count_t  cfg_words,
    input  logic                 load_valid,
    input  glb_pkg::glb_data_t   load_data,
    input  logic                 drain_done,
    output logic                 load_ready,
    output glb_pkg::glb_wr_req_t wr_req,
    output glb_pkg::glb_fill_t   fill
);

    import glb_pkg::*;

    loader_state_t state;
    glb_count_t    batch_len;
    glb_count_t    load_cnt;      // Words accepted so far.
    glb_count_t    len_now;
    logic          accept;
    logic          last_word;

    logic          wr_en;
    glb_addr_t     wr_addr;
    glb_data_t     wr_data;
    logic          fill_done;
    glb_count_t    fill_words;

    assign load_ready = (state == ld_idle);
    assign accept     = load_ready & load_valid;

    // First word of a batch sees cfg_words directly.
    assign len_now   = (load_cnt == '0) ? cfg_words : batch_len;
    assign last_word = (load_cnt + 1'b1) >= len_now;

    // ##################################################
    // Batch FSM
    // ##################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ld_idle;
            batch_len <= '0;
            load_cnt  <= '0;
        end else begin
            case (state)
                ld_idle: begin
                    if (accept) begin
                        if (load_cnt == '0) begin
                            batch_len <= cfg_words;
                        end
                        load_cnt <= load_cnt + 1'b1;
                        if (last_word) begin
                            state <= ld_fill;
                        end
                    end
                end
                ld_fill: begin
                    state <= ld_wait_drain;     // Last write on the bus.
                end
                ld_wait_drain: begin
                    if (drain_done) begin
                        load_cnt <= '0;
                        state    <= ld_idle;
                    end
                end
                default: begin
                    state <= ld_idle;
                end
            endcase
        end
    end

    // ##################################################
    // Write requests
    // ##################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en   <= 1'b0;
            wr_addr <= '0;
        end else begin
            wr_en <= accept;
            if (accept) begin
                wr_addr <= glb_addr_t'(load_cnt);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_data <= load_data;
        end
    end

    assign wr_req = '{en: wr_en, addr: wr_addr, data: wr_data};

    // Batch handoff, one cycle after the last write.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_done  <= 1'b0;
            fill_words <= '0;
        end else begin
            fill_done <= (state == ld_fill);
            if (state == ld_fill) begin
                fill_words <= load_cnt;
            end
        end
    end

    assign fill = '{done: fill_done, words: fill_words};

endmodule

// ==== glb_drainer.sv ====
`timescale 1ns/100ps
`include "glb_settings.svh"

module glb_drainer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  glb_pkg::glb_fill_t   fill,
    input  logic                 out_hold,
    input  glb_pkg::glb_data_t   rd_data,
    output glb_pkg::glb_rd_req_t rd_req,
    output logic                 out_valid,
    output glb_pkg::glb_data_t   out_data,
    output logic                 sum_valid,
    output glb_pkg::glb_data_t   sum_data,
    output logic                 drain_done
);

    import glb_pkg::*;

    drainer_state_t state;
    glb_count_t     total;        // Words in this batch.
    glb_count_t     rd_cnt;       // Reads issued so far.
    logic           issue;
    logic           last_issue;
    logic           last_return;
    logic           rd_en;
    glb_addr_t      rd_addr;
    glb_data_t      sum_acc;

    assign issue      = (state == dr_read) & ~out_hold;
    assign last_issue = issue & ((rd_cnt + 1'b1) >= total);

    // Final word arrives once no request is left behind it.
    assign last_return = (state == dr_sum) & out_valid & ~rd_en;

    // ##################################################
    // Drain FSM
    // ##################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= dr_idle;
            total  <= '0;
            rd_cnt <= '0;
        end else begin
            case (state)
                dr_idle: begin
                    if (fill.done) begin
                        total  <= fill.words;
                        rd_cnt <= '0;
                        state  <= dr_read;
                    end
                end
                dr_read: begin
                    if (issue) begin
                        rd_cnt <= rd_cnt + 1'b1;
                        if (last_issue) begin
                            state <= dr_sum;
                        end
                    end
                end
                dr_sum: begin
                    if (last_return) begin
                        state <= dr_idle;
                    end
                end
                default: begin
                    state <= dr_idle;
                end
            endcase
        end
    end

    // ##################################################
    // Read requests and output
    // ##################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en   <= 1'b0;
            rd_addr <= '0;
        end else begin
            rd_en <= issue;
            if (issue) begin
                rd_addr <= glb_addr_t'(rd_cnt);
            end
        end
    end

    assign rd_req = '{en: rd_en, addr: rd_addr};

    // At most one read in flight.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;
        end
    end

    assign out_data = rd_data;    // Fresh word from the bank.

    // ##################################################
    // Checksum
    // ##################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_acc   <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= last_return;
            if (out_valid) begin
                sum_acc <= sum_acc + rd_data;    // Wraps modulo word width.
            end else if (sum_valid) begin
                sum_acc <= '0;
            end
        end
    end

    assign sum_data   = sum_acc;
    assign drain_done = sum_valid;    // Bank goes back to the loader.

endmodule

// ==== glb_top.sv ====
`timescale 1ns/100ps
`include "glb_settings.svh"

module glb_top (
    input  logic                clk,
    input  logic                rst_n,
    input  glb_pkg::glb_count_t cfg_words,
    input  logic                load_valid,
    input  glb_pkg::glb_data_t  load_data,
    input  logic                out_hold,
    output logic                load_ready,
    output logic                out_valid,
    output glb_pkg::glb_data_t  out_data,
    output logic                sum_valid,
    output glb_pkg::glb_data_t  sum_data
);

    import glb_pkg::*;

    glb_wr_req_t wr_req;
    glb_rd_req_t rd_req;
    glb_data_t   rd_data;
    glb_fill_t   fill;
    logic        drain_done;

    // Producer side.
    glb_loader u_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_words  (cfg_words),
        .load_valid (load_valid),
        .load_data  (load_data),
        .drain_done (drain_done),
        .load_ready (load_ready),
        .wr_req     (wr_req),
        .fill       (fill)
    );

    glb_ram u_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_req  (wr_req),
        .rd_req  (rd_req),
        .rd_data (rd_data)
    );

    // Consumer side.
    glb_drainer u_drainer (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill       (fill),
        .out_hold   (out_hold),
        .rd_data    (rd_data),
        .rd_req     (rd_req),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .sum_valid  (sum_valid),
        .sum_data   (sum_data),
        .drain_done (drain_done)
    );

endmodule

// ==== tb_glb_top.sv ====
`timescale 1ns/100ps
`include "glb_settings.svh"

module tb_glb_top;

    import glb_pkg::*;

    // Timeout scales with the words loaded.
    localparam int TOTAL_WORDS = 8 + `GLB_SRAM_WORD + 1 + 24 + 4 + 2;
    localparam int CYCLE_LIMIT = TOTAL_WORDS * 8 + 500;

    logic       clk;
    logic       rst_n;
    glb_count_t cfg_words;
    logic       load_valid;
    glb_data_t  load_data;
    logic       out_hold;
    logic       load_ready;
    logic       out_valid;
    glb_data_t  out_data;
    logic       sum_valid;
    glb_data_t  sum_data;

    integer     seed;
    integer     rnd;
    int         word_errors  = 0;
    int         sum_errors   = 0;
    int         other_errors = 0;
    int         sums_seen    = 0;
    int         words_in_batch = 0;
    int         hold_run     = 0;
    int         cycle_cnt    = 0;
    int         i;
    glb_data_t  held_word    = '0;    // Last word out, zero after reset.

    glb_data_t  batch_mem [`GLB_SRAM_WORD];
    glb_data_t  exp_word_q [$];
    glb_data_t  exp_sum_q [$];
    int         exp_len_q [$];

    glb_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_words  (cfg_words),
        .load_valid (load_valid),
        .load_data  (load_data),
        .out_hold   (out_hold),
        .load_ready (load_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .sum_valid  (sum_valid),
        .sum_data   (sum_data)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ##################################################
    // Reference model and compare tasks
    // ##################################################
    function automatic glb_data_t ref_checksum(input int n);
        glb_data_t acc;
        int        k;
        acc = '0;
        for (k = 0; k < n; k++) begin
            acc = acc + batch_mem[k];    // Wraps at word width.
        end
        return acc;
    endfunction

    task automatic check_word(input glb_data_t exp, input glb_data_t act);
        if (act !== exp) begin
            $display("Error out_data: expected %h, got %h", exp, act);
            word_errors++;
        end
    endtask

    task automatic check_sum(input glb_data_t exp, input glb_data_t act);
        if (act !== exp) begin
            $display("Error sum_data: expected %h, got %h", exp, act);
            sum_errors++;
        end
    endtask

    task automatic report_counts;
        $display("Errors: out_data %0d, sum_data %0d, other %0d",
                 word_errors, sum_errors, other_errors);
    endtask

    // ##################################################
    // Stimulus tasks
    // ##################################################
    task automatic load_word(input glb_data_t d);
        load_valid = 1'b1;
        load_data  = d;
        while (!load_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);    // Accepted here.
        #1;
        load_valid = 1'b0;
        exp_word_q.push_back(d);
    endtask

    task automatic load_batch(input int n, input int max_gap);
        int k;
        int gap;
        cfg_words = glb_count_t'(n);
        for (k = 0; k < n; k++) begin
            load_word(batch_mem[k]);
            cfg_words = glb_count_t'(1);    // Length is already latched.
            if (k < n - 1 && max_gap > 0) begin
                gap = $unsigned($random(seed)) % (max_gap + 1);
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        exp_sum_q.push_back(ref_checksum(n));
        exp_len_q.push_back(n);
    endtask

    task automatic wait_batches(input int n);
        while (sums_seen < n) begin
            @(posedge clk);
        end
        #1;
    endtask

    // ##################################################
    // Output monitor
    // ##################################################
    always @(negedge clk) begin
        if (rst_n) begin
            hold_run = out_hold ? hold_run + 1 : 0;
            if (out_valid && hold_run >= 3) begin
                $display("out_valid seen more than two cycles after out_hold went high");
                other_errors++;
            end
            if (out_valid) begin
                if (exp_word_q.size() == 0) begin
                    $display("out_valid seen with no loaded word pending");
                    other_errors++;
                end else begin
                    held_word = exp_word_q.pop_front();
                    check_word(held_word, out_data);
                end
                words_in_batch++;
            end else begin
                check_word(held_word, out_data);    // Bank output holds the last word.
            end
            if (sum_valid) begin
                if (exp_sum_q.size() == 0) begin
                    $display("sum_valid seen with no finished batch pending");
                    other_errors++;
                end else begin
                    check_sum(exp_sum_q.pop_front(), sum_data);
                    if (words_in_batch != exp_len_q.pop_front()) begin
                        $display("Batch ended after %0d words, the wrong word count",
                                 words_in_batch);
                        other_errors++;
                    end
                end
                words_in_batch = 0;
                sums_seen++;
            end
        end
    end

    // Watchdog.
    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        report_counts;
        $display("Checks failed");
        $finish;
    end

    // ##################################################
    // Main sequence
    // ##################################################
    initial begin
        seed       = 76429;
        rst_n      = 1'b0;
        cfg_words  = '0;
        load_valid = 1'b0;
        load_data  = '0;
        out_hold   = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle after reset.
        repeat (5) begin
            if (!load_ready || out_valid || sum_valid) begin
                $display("Wrong state after reset: load_ready %0b, out_valid %0b, sum_valid %0b",
                         load_ready, out_valid, sum_valid);
                other_errors++;
            end
            @(posedge clk);
            #1;
        end

        // Fixed batch loaded back to back.
        batch_mem[0] = glb_data_t'(32'h0000_0001);
        batch_mem[1] = glb_data_t'(32'h1234_5678);
        batch_mem[2] = glb_data_t'(32'hdead_beef);
        batch_mem[3] = glb_data_t'(32'hcafe_f00d);
        batch_mem[4] = glb_data_t'(32'h8000_0000);
        batch_mem[5] = glb_data_t'(32'h0f0f_0f0f);
        batch_mem[6] = glb_data_t'(32'hffff_fffe);
        batch_mem[7] = glb_data_t'(32'h5555_aaaa);
        load_batch(8, 0);
        wait_batches(1);

        // Full bank with gaps and then one word.
        for (i = 0; i < `GLB_SRAM_WORD; i++) begin
            batch_mem[i] = glb_data_t'($random(seed));
        end
        load_batch(`GLB_SRAM_WORD, 3);
        batch_mem[0] = glb_data_t'($random(seed));
        load_batch(1, 0);
        wait_batches(3);

        // Back-pressure during the drain.
        for (i = 0; i < 24; i++) begin
            batch_mem[i] = glb_data_t'($random(seed));
        end
        load_batch(24, 0);
        while (sums_seen < 4) begin
            rnd      = $random(seed);
            out_hold = rnd[0];
            @(posedge clk);
            #1;
        end
        out_hold = 1'b0;

        // All-ones batch and stray pulses while the drainer owns the bank.
        for (i = 0; i < 4; i++) begin
            batch_mem[i] = '1;
        end
        load_batch(4, 0);
        for (i = 0; i < 6; i++) begin
            if (load_ready) begin
                $display("load_ready high while the batch is still draining");
                other_errors++;
            end
            load_valid = (i % 2 == 0);
            load_data  = glb_data_t'(32'h0bad_0000 + i);
            @(posedge clk);
            #1;
        end
        load_valid = 1'b0;
        wait_batches(5);
        batch_mem[0] = glb_data_t'(32'h0000_0003);
        batch_mem[1] = glb_data_t'(32'h7fff_ffff);
        load_batch(2, 0);
        wait_batches(6);

        // Quiet cycles catch stray outputs.
        repeat (20) @(posedge clk);
        if (exp_word_q.size() != 0) begin
            $display("%0d loaded words never came out", exp_word_q.size());
            other_errors++;
        end
        if (exp_sum_q.size() != 0) begin
            $display("%0d batches never produced a checksum", exp_sum_q.size());
            other_errors++;
        end
        report_counts;
        if (word_errors + sum_errors + other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== glb_stream.f ====
+incdir+.
glb_pkg.sv
glb_ram.sv
glb_loader.sv
glb_drainer.sv
glb_top.sv
tb_glb_top.sv

// ==== Bender.yml ====
package:
  name: glb_stream

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - glb_pkg.sv
      - glb_ram.sv
      - glb_loader.sv
      - glb_drainer.sv
      - glb_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_glb_top.sv
